// File: src/opll_pkg.sv
//////////////////////////////
// register map, field types and scanner states of the OPLL front end
// channel count is fixed by the chip's register map
//////////////////////////////
`default_nettype none

package opll_pkg;

	typedef logic [5:0]  reg_addr_t;
	typedef logic [7:0]  reg_data_t;
	typedef logic [8:0]  fnum_t;
	typedef logic [2:0]  block_t;
	typedef logic [3:0]  inst_t;
	typedef logic [3:0]  vol_t;
	typedef logic [3:0]  chan_idx_t;
	typedef logic [15:0] phase_inc_t;
	typedef logic [2:0]  lane_mask_t;

	// en, bd, sd, tom, cym, hh from msb to lsb
	typedef logic [5:0]  rhythm_t;

	// register 00 in the low byte, register 07 in the high byte
	typedef logic [63:0] user_patch_t;

	// {inst, vol} {sust, key, block, fnum[8]} {fnum[7:0]}
	typedef logic [21:0] chan_word_t;

	localparam int CHAN_COUNT = 9;

	// channel group bases, channel number in the low nibble
	localparam reg_addr_t ADDR_FNUM_LO  = 6'h10;
	localparam reg_addr_t ADDR_CTRL     = 6'h20;
	localparam reg_addr_t ADDR_INST_VOL = 6'h30;
	localparam reg_addr_t ADDR_RHYTHM   = 6'h0e;

	// bit positions in lane_mask_t
	localparam int LANE_FNUM_LO  = 0;
	localparam int LANE_CTRL     = 1;
	localparam int LANE_INST_VOL = 2;

	// lsb of each lane inside chan_word_t
	localparam int WORD_FNUM_LO_LSB  = 0;
	localparam int WORD_CTRL_LSB     = 8;
	localparam int WORD_INST_VOL_LSB = 14;

	typedef enum logic [1:0] {
		SCAN_REQ,
		SCAN_WAIT,
		SCAN_EMIT
	} scan_state_t;

endpackage

`default_nettype wire

// File: src/opll_reg_decoder.sv
//////////////////////////////
// host register port: sel_reg latches the address, sel_dat writes d
// sel_dat needs an idle cycle between two writes
// channel writes leave as a same-cycle request, no read-back
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opll_reg_decoder (
	input  wire                           clk,
	input  wire                           reset,
	input  wire opll_pkg::reg_data_t      d,
	input  wire                           sel_reg,
	input  wire                           sel_dat,
	output opll_pkg::user_patch_t         ut_patch,
	output opll_pkg::rhythm_t             rhythm,
	output logic                          wr_req,
	output opll_pkg::chan_idx_t           wr_chan,
	output opll_pkg::lane_mask_t          wr_lane,
	output opll_pkg::chan_word_t          wr_data
);

	opll_pkg::reg_addr_t reg_addr;
	opll_pkg::reg_addr_t grp_base;
	opll_pkg::reg_data_t patch_byte;

	// address latch
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_addr <= '0;
		end
		else if (sel_reg) begin
			reg_addr <= d[5:0];
		end
	end

	always_comb begin
		patch_byte = d;
		if (reg_addr[2:0] == 3'd3) begin
			patch_byte[5] = 1'b0; // unused on the chip
		end
	end

	// user patch 00-07 and rhythm 0E
	always_ff @(posedge clk) begin
		if (reset) begin
			ut_patch <= '0;
			rhythm   <= '0;
		end
		else if (sel_dat) begin
			if (reg_addr[5:3] == 3'b000) begin
				ut_patch[{reg_addr[2:0], 3'b000} +: 8] <= patch_byte;
			end
			if (reg_addr == opll_pkg::ADDR_RHYTHM) begin
				rhythm <= d[5:0];
			end
		end
	end

	assign grp_base = {reg_addr[5:4], 4'h0};
	assign wr_chan  = reg_addr[3:0];

	// place the byte in its lane of the channel word
	always_comb begin
		wr_lane = '0;
		wr_data = '0;
		case (grp_base)
			opll_pkg::ADDR_FNUM_LO: begin
				wr_lane[opll_pkg::LANE_FNUM_LO] = 1'b1;
				wr_data[opll_pkg::WORD_FNUM_LO_LSB +: 8] = d;
			end
			opll_pkg::ADDR_CTRL: begin
				wr_lane[opll_pkg::LANE_CTRL] = 1'b1;
				wr_data[opll_pkg::WORD_CTRL_LSB +: 6] = d[5:0]; // sust, key, block, fnum msb
			end
			opll_pkg::ADDR_INST_VOL: begin
				wr_lane[opll_pkg::LANE_INST_VOL] = 1'b1;
				wr_data[opll_pkg::WORD_INST_VOL_LSB +: 8] = d;
			end
			default: begin
				wr_lane = '0;
			end
		endcase
	end

	// one cycle wide since sel_dat is; channels 9-15 are dropped
	assign wr_req = sel_dat && (wr_lane != '0) && (wr_chan < opll_pkg::CHAN_COUNT);

endmodule

`default_nettype wire

// File: src/opll_chan_ram.sv
//////////////////////////////
// nine-word channel memory, lane write enables, one-cycle read
// a read in a write cycle returns the old word
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opll_chan_ram (
	input  wire                       clk,
	input  wire                       reset,
	input  wire opll_pkg::chan_idx_t  addr,
	input  wire opll_pkg::lane_mask_t we,
	input  wire opll_pkg::chan_word_t wdata,
	output opll_pkg::chan_word_t      rdata
);

	opll_pkg::chan_word_t mem [opll_pkg::CHAN_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < opll_pkg::CHAN_COUNT; i++) begin
				mem[i] <= '0;
			end
		end
		else if (addr < opll_pkg::CHAN_COUNT) begin
			if (we[opll_pkg::LANE_FNUM_LO]) begin
				mem[addr][opll_pkg::WORD_FNUM_LO_LSB +: 8] <= wdata[opll_pkg::WORD_FNUM_LO_LSB +: 8];
			end
			if (we[opll_pkg::LANE_CTRL]) begin
				mem[addr][opll_pkg::WORD_CTRL_LSB +: 6] <= wdata[opll_pkg::WORD_CTRL_LSB +: 6];
			end
			if (we[opll_pkg::LANE_INST_VOL]) begin
				mem[addr][opll_pkg::WORD_INST_VOL_LSB +: 8] <= wdata[opll_pkg::WORD_INST_VOL_LSB +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (addr < opll_pkg::CHAN_COUNT) begin
			rdata <= mem[addr];
		end
		else begin
			rdata <= '0; // out of range reads as zero
		end
	end

endmodule

`default_nettype wire

// File: src/opll_ram_arbiter.sv
//////////////////////////////
// one-entry write buffer, round-robin port sharing with the scanner
// relies on the idle cycle between host writes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opll_ram_arbiter (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       wr_req,
	input  wire opll_pkg::chan_idx_t  wr_chan,
	input  wire opll_pkg::lane_mask_t wr_lane,
	input  wire opll_pkg::chan_word_t wr_data,
	input  wire                       rd_req,
	input  wire opll_pkg::chan_idx_t  rd_chan,
	input  wire opll_pkg::chan_word_t rdata,
	output logic                      rd_valid,
	output opll_pkg::chan_word_t      rd_data,
	output opll_pkg::chan_idx_t       mem_addr,
	output opll_pkg::lane_mask_t      mem_we,
	output opll_pkg::chan_word_t      mem_wdata
);

	logic                 buf_valid;
	opll_pkg::chan_idx_t  buf_chan;
	opll_pkg::lane_mask_t buf_lane;
	logic                 last_wr;   // write side won the last contest
	logic                 rd_pend;
	logic                 gnt_wr;
	logic                 gnt_rd;

	assign rd_pend = rd_req && !rd_valid; // scanner still holds rd_req while rd_valid is up
	assign gnt_wr  = buf_valid && (!rd_pend || !last_wr);
	assign gnt_rd  = rd_pend && !gnt_wr;

	always_ff @(posedge clk) begin
		if (reset) begin
			buf_valid <= 1'b0;
			last_wr   <= 1'b0;
			rd_valid  <= 1'b0;
		end
		else begin
			// a new entry may arrive in the cycle the old one is written
			if (wr_req) begin
				buf_valid <= 1'b1;
			end
			else if (gnt_wr) begin
				buf_valid <= 1'b0;
			end
			if (buf_valid && rd_pend) begin
				last_wr <= ~last_wr;
			end
			rd_valid <= gnt_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_req) begin
			buf_chan  <= wr_chan;
			buf_lane  <= wr_lane;
			mem_wdata <= wr_data;
		end
	end

	assign mem_addr = gnt_rd ? rd_chan : buf_chan;
	assign mem_we   = gnt_wr ? buf_lane : '0;
	assign rd_data  = rdata;

endmodule

`default_nettype wire

// File: src/opll_chan_scanner.sv
//////////////////////////////
// loops over channels 0-8, one record per channel
// records at least three cycles apart, rhythm forces keys on 6-8
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opll_chan_scanner (
	input  wire                       clk,
	input  wire                       reset,
	input  wire opll_pkg::rhythm_t    rhythm,
	input  wire                       rd_valid,
	input  wire opll_pkg::chan_word_t rd_data,
	output logic                      rd_req,
	output opll_pkg::chan_idx_t       rd_chan,
	output logic                      chan_valid,
	output opll_pkg::chan_idx_t       chan_idx,
	output opll_pkg::phase_inc_t      phase_inc,
	output logic                      key_on,
	output logic                      sust_on,
	output opll_pkg::inst_t           inst,
	output opll_pkg::vol_t            vol
);

	opll_pkg::scan_state_t state;
	opll_pkg::fnum_t       fnum;
	opll_pkg::block_t      block;
	logic                  key_rhy;

	assign fnum  = {rd_data[opll_pkg::WORD_CTRL_LSB], rd_data[opll_pkg::WORD_FNUM_LO_LSB +: 8]};
	assign block = rd_data[opll_pkg::WORD_CTRL_LSB + 1 +: 3];

	// rhythm bits: en bd sd tom cym hh
	always_comb begin
		case (rd_chan)
			4'd6:    key_rhy = rhythm[4];             // bass drum
			4'd7:    key_rhy = rhythm[3] | rhythm[0]; // snare, hi-hat
			4'd8:    key_rhy = rhythm[2] | rhythm[1]; // tom, cymbal
			default: key_rhy = 1'b0;
		endcase
	end

	assign rd_req = (state == opll_pkg::SCAN_REQ) || (state == opll_pkg::SCAN_WAIT);

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= opll_pkg::SCAN_REQ;
			rd_chan    <= '0;
			chan_valid <= 1'b0;
		end
		else begin
			chan_valid <= 1'b0;
			case (state)
				opll_pkg::SCAN_REQ: state <= opll_pkg::SCAN_WAIT;
				opll_pkg::SCAN_WAIT: begin
					if (rd_valid) begin
						state      <= opll_pkg::SCAN_EMIT;
						chan_valid <= 1'b1;
					end
				end
				opll_pkg::SCAN_EMIT: begin
					state   <= opll_pkg::SCAN_REQ;
					rd_chan <= (rd_chan == opll_pkg::CHAN_COUNT - 1) ? '0 : rd_chan + 1'b1;
				end
				default: state <= opll_pkg::SCAN_REQ;
			endcase
		end
	end

	// record fields, valid with chan_valid
	always_ff @(posedge clk) begin
		if (state == opll_pkg::SCAN_WAIT && rd_valid) begin
			chan_idx  <= rd_chan;
			phase_inc <= opll_pkg::phase_inc_t'(fnum) << block;
			key_on    <= rd_data[opll_pkg::WORD_CTRL_LSB + 4] | (rhythm[5] & key_rhy);
			sust_on   <= rd_data[opll_pkg::WORD_CTRL_LSB + 5];
			inst      <= rd_data[opll_pkg::WORD_INST_VOL_LSB + 4 +: 4];
			vol       <= rd_data[opll_pkg::WORD_INST_VOL_LSB +: 4];
		end
	end

endmodule

`default_nettype wire

// File: src/opll_ctrl_top.sv
//////////////////////////////
// OPLL control front end: register decoder, channel memory, scanner
// plain strobes only, no back-pressure to the host
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opll_ctrl_top (
	input  wire                      clk,
	input  wire                      reset,
	input  wire opll_pkg::reg_data_t d,
	input  wire                      sel_reg,
	input  wire                      sel_dat,
	output opll_pkg::user_patch_t    ut_patch,
	output opll_pkg::rhythm_t        rhythm,
	output logic                     chan_valid,
	output opll_pkg::chan_idx_t      chan_idx,
	output opll_pkg::phase_inc_t     phase_inc,
	output logic                     key_on,
	output logic                     sust_on,
	output opll_pkg::inst_t          inst,
	output opll_pkg::vol_t           vol
);

	// decoder to arbiter
	logic                 wr_req;
	opll_pkg::chan_idx_t  wr_chan;
	opll_pkg::lane_mask_t wr_lane;
	opll_pkg::chan_word_t wr_data;

	// scanner to arbiter
	logic                 rd_req;
	opll_pkg::chan_idx_t  rd_chan;
	logic                 rd_valid;
	opll_pkg::chan_word_t rd_data;

	// memory port
	opll_pkg::chan_idx_t  mem_addr;
	opll_pkg::lane_mask_t mem_we;
	opll_pkg::chan_word_t mem_wdata;
	opll_pkg::chan_word_t mem_rdata;

	opll_reg_decoder u_decoder (
		.clk, .reset, .d, .sel_reg, .sel_dat,
		.ut_patch, .rhythm,
		.wr_req, .wr_chan, .wr_lane, .wr_data
	);

	opll_ram_arbiter u_arbiter (
		.clk, .reset,
		.wr_req, .wr_chan, .wr_lane, .wr_data,
		.rd_req, .rd_chan,
		.rdata (mem_rdata),
		.rd_valid, .rd_data,
		.mem_addr, .mem_we, .mem_wdata
	);

	opll_chan_ram u_chan_ram (
		.clk, .reset,
		.addr  (mem_addr),
		.we    (mem_we),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

	opll_chan_scanner u_scanner (
		.clk, .reset, .rhythm, .rd_valid, .rd_data,
		.rd_req, .rd_chan,
		.chan_valid, .chan_idx, .phase_inc, .key_on, .sust_on, .inst, .vol
	);

endmodule

`default_nettype wire

// File: test/opll_ctrl_properties.sv
//////////////////////////////
// assertions bound into opll_ctrl_top
// fail_count counts failed assertions for the testbench
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opll_ctrl_properties (
	input wire                       clk,
	input wire                       reset,
	input wire                       sel_dat,
	input wire                       chan_valid,
	input wire opll_pkg::chan_idx_t  chan_idx,
	input wire opll_pkg::lane_mask_t mem_we,
	input wire                       rd_valid
);

	int fail_count = 0;

	idx_in_range: assert property (@(posedge clk) disable iff (reset)
		chan_valid |-> (chan_idx < opll_pkg::CHAN_COUNT))
		else begin
			$error("record carries channel %0d", chan_idx);
			fail_count++;
		end

	valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
		chan_valid |=> !chan_valid)
		else begin
			$error("chan_valid high for two cycles");
			fail_count++;
		end

	// a write grant excludes a read grant, which shows as rd_valid next cycle
	no_wr_and_rd: assert property (@(posedge clk) disable iff (reset)
		(mem_we != '0) |=> !rd_valid)
		else begin
			$error("memory write and read granted in the same cycle");
			fail_count++;
		end

	dat_gap: assert property (@(posedge clk) disable iff (reset)
		sel_dat |=> !sel_dat)
		else begin
			$error("sel_dat on two consecutive cycles");
			fail_count++;
		end

endmodule

bind opll_ctrl_top opll_ctrl_properties u_props (.*);

`default_nettype wire

// File: test/opll_ctrl_tb.sv
//////////////////////////////
// replays test/opll_ctrl_input.txt against opll_ctrl_top
// stops at the first error, each record wait gives up after 200 cycles
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opll_ctrl_tb;

	localparam int REC_TIMEOUT = 200;

	typedef logic [8*24-1:0] label_t;

	logic                  clk;
	logic                  reset;
	opll_pkg::reg_data_t   d;
	logic                  sel_reg;
	logic                  sel_dat;
	opll_pkg::user_patch_t ut_patch;
	opll_pkg::rhythm_t     rhythm;
	logic                  chan_valid;
	opll_pkg::chan_idx_t   chan_idx;
	opll_pkg::phase_inc_t  phase_inc;
	logic                  key_on;
	logic                  sust_on;
	opll_pkg::inst_t       inst;
	opll_pkg::vol_t        vol;
	opll_pkg::chan_idx_t   next_idx; // channel the next record must carry

	opll_ctrl_top dut0 (
		.clk, .reset, .d, .sel_reg, .sel_dat,
		.ut_patch, .rhythm,
		.chan_valid, .chan_idx, .phase_inc, .key_on, .sust_on, .inst, .vol
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_patch(input label_t name, input opll_pkg::user_patch_t exp,
		input opll_pkg::user_patch_t act);
		if (act !== exp) begin
			$display("FAIL %0s: expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_rhythm(input label_t name, input opll_pkg::rhythm_t exp,
		input opll_pkg::rhythm_t act);
		if (act !== exp) begin
			$display("FAIL %0s: expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_index(input label_t name, input opll_pkg::chan_idx_t exp,
		input opll_pkg::chan_idx_t act);
		if (act !== exp) begin
			$display("FAIL %0s: expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	// compares the record on the outputs, phase_inc from the shift rule
	task automatic check_record(input label_t name, input opll_pkg::chan_idx_t exp_idx,
		input opll_pkg::fnum_t exp_fnum, input opll_pkg::block_t exp_block,
		input logic exp_key, input logic exp_sust,
		input opll_pkg::inst_t exp_inst, input opll_pkg::vol_t exp_vol);
		opll_pkg::phase_inc_t exp_inc;
		string                exp_s;
		string                act_s;
		exp_inc = exp_fnum;
		repeat (exp_block) begin
			exp_inc = exp_inc * 2; // one octave up doubles the increment
		end
		if (chan_idx !== exp_idx || phase_inc !== exp_inc || key_on !== exp_key ||
			sust_on !== exp_sust || inst !== exp_inst || vol !== exp_vol) begin
			exp_s = $sformatf("ch %0d inc %h key %b sust %b inst %h vol %h",
				exp_idx, exp_inc, exp_key, exp_sust, exp_inst, exp_vol);
			act_s = $sformatf("ch %0d inc %h key %b sust %b inst %h vol %h",
				chan_idx, phase_inc, key_on, sust_on, inst, vol);
			$display("FAIL %0s: expected %0s actual %0s", name, exp_s, act_s);
			stop_run();
		end
	endtask

	// second record of a channel is read after every earlier write landed
	task automatic wait_record(input label_t name, input opll_pkg::chan_idx_t ch);
		int seen;
		int cycles;
		seen = 0;
		while (seen < 2) begin
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
			end while (!(chan_valid && chan_idx == ch) && cycles < REC_TIMEOUT);
			if (!(chan_valid && chan_idx == ch)) begin
				$display("record for channel %0d (%0s) did not arrive within %0d cycles",
					ch, name, REC_TIMEOUT);
				stop_run();
			end
			else begin
				seen++;
			end
		end
	endtask

	// address cycle, idle, data cycle, idle
	task automatic write_reg(input opll_pkg::reg_addr_t addr, input opll_pkg::reg_data_t data);
		@(posedge clk);
		d       <= {2'b00, addr};
		sel_reg <= 1'b1;
		@(posedge clk);
		sel_reg <= 1'b0;
		@(posedge clk);
		d       <= data;
		sel_dat <= 1'b1;
		@(posedge clk);
		sel_dat <= 1'b0;
		@(posedge clk);
	endtask

	always @(negedge clk) begin
		if (reset) begin
			next_idx = '0;
		end
		else if (chan_valid) begin
			check_index("scan_order", next_idx, chan_idx);
			next_idx = (next_idx == opll_pkg::CHAN_COUNT - 1) ? '0 : next_idx + 1'b1;
		end
	end

	// bound assertions count their failures
	always @(negedge clk) begin
		if (dut0.u_props.fail_count != 0) begin
			$display("%0d assertion failures in the bound checks", dut0.u_props.fail_count);
			stop_run();
		end
	end

	initial begin
		int                    fd;
		int                    n;
		logic [8*96-1:0]       line;
		logic [8*8-1:0]        cmd;
		label_t                name;
		opll_pkg::reg_addr_t   w_addr;
		opll_pkg::reg_data_t   w_data;
		opll_pkg::user_patch_t e_patch;
		opll_pkg::rhythm_t     e_rhythm;
		opll_pkg::chan_idx_t   e_ch;
		opll_pkg::fnum_t       e_fnum;
		opll_pkg::block_t      e_block;
		logic                  e_key;
		logic                  e_sust;
		opll_pkg::inst_t       e_inst;
		opll_pkg::vol_t        e_vol;
		reset   = 1'b1;
		d       = '0;
		sel_reg = 1'b0;
		sel_dat = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		fd = $fopen("test/opll_ctrl_input.txt", "r");
		if (fd == 0) begin
			$display("command file test/opll_ctrl_input.txt could not be opened");
			stop_run();
		end
		while ($fgets(line, fd) != 0) begin
			cmd  = '0;
			name = '0;
			n = $sscanf(line, "%s", cmd);
			if (n < 1 || cmd == "#") begin
				n = 0; // blank or comment line
			end
			else if (cmd == "write") begin
				n = $sscanf(line, "%s %h %h", cmd, w_addr, w_data);
				write_reg(w_addr, w_data);
			end
			else if (cmd == "patch") begin
				n = $sscanf(line, "%s %s %h", cmd, name, e_patch);
				@(negedge clk);
				check_patch(name, e_patch, ut_patch);
			end
			else if (cmd == "rhythm") begin
				n = $sscanf(line, "%s %s %h", cmd, name, e_rhythm);
				@(negedge clk);
				check_rhythm(name, e_rhythm, rhythm);
			end
			else if (cmd == "chan") begin
				n = $sscanf(line, "%s %s %h %h %h %h %h %h %h", cmd, name, e_ch,
					e_fnum, e_block, e_key, e_sust, e_inst, e_vol);
				wait_record(name, e_ch);
				check_record(name, e_ch, e_fnum, e_block, e_key, e_sust, e_inst, e_vol);
			end
			else begin
				$display("unknown command %0s in the command file", cmd);
				stop_run();
			end
		end
		$fclose(fd);
		repeat (4) @(negedge clk);
		if (dut0.u_props.fail_count != 0) begin
			$display("%0d assertion failures in the bound checks", dut0.u_props.fail_count);
			stop_run();
		end
		else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/opll_ctrl_input.txt
# write <addr> <data> | patch <name> <value> | rhythm <name> <value>
# chan <name> <ch> <fnum> <block> <key> <sust> <inst> <vol>, numbers in hex
patch reset_patch 0000000000000000
rhythm reset_rhythm 00
chan reset_ch0 0 000 0 0 0 0 0
chan reset_ch1 1 000 0 0 0 0 0
chan reset_ch2 2 000 0 0 0 0 0
chan reset_ch3 3 000 0 0 0 0 0
chan reset_ch4 4 000 0 0 0 0 0
chan reset_ch5 5 000 0 0 0 0 0
chan reset_ch6 6 000 0 0 0 0 0
chan reset_ch7 7 000 0 0 0 0 0
chan reset_ch8 8 000 0 0 0 0 0
# user patch bytes, 0a and 19 are not mapped
write 00 21
write 03 ff
write 07 5a
write 0a 77
write 19 33
patch patch_bytes 5a000000df000021
write 12 c5
write 22 37
write 32 a4
chan ch2_full 2 1c5 3 1 1 a 4
write 32 6f
chan ch2_inst_only 2 1c5 3 1 1 6 f
write 12 00
chan ch2_fnum_only 2 100 3 1 1 6 f
write 18 ff
write 28 0f
write 38 12
chan ch8_full 8 1ff 7 0 0 1 2
# rhythm on with bass drum, snare and cymbal
write 0e 3a
rhythm rhythm_on 3a
chan rhy_on_ch6 6 000 0 1 0 0 0
chan rhy_on_ch7 7 000 0 1 0 0 0
chan rhy_on_ch8 8 1ff 7 1 0 1 2
write 0e 1a
write 27 10
rhythm rhythm_off 1a
chan rhy_off_ch6 6 000 0 0 0 0 0
chan rhy_off_ch7 7 000 0 1 0 0 0
chan rhy_off_ch8 8 1ff 7 0 0 1 2
patch patch_final 5a000000df000021

// File: build.f
src/opll_pkg.sv
src/opll_reg_decoder.sv
src/opll_chan_ram.sv
src/opll_ram_arbiter.sv
src/opll_chan_scanner.sv
src/opll_ctrl_top.sv
test/opll_ctrl_properties.sv
test/opll_ctrl_tb.sv

// File: Bender.yml
package:
  name: opll_ctrl

sources:
  - src/opll_pkg.sv
  - src/opll_reg_decoder.sv
  - src/opll_chan_ram.sv
  - src/opll_ram_arbiter.sv
  - src/opll_chan_scanner.sv
  - src/opll_ctrl_top.sv
  - target: test
    files:
      - test/opll_ctrl_properties.sv
      - test/opll_ctrl_tb.sv
